// File: src/fprf_macros.svh
// Sizing macros for the FP register-read path: writeback ports, physical registers, data width
`ifndef FPRF_MACROS_SVH
`define FPRF_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Writeback ports into the FP register file
`define FP_NUM_WB 2

// Physical FP registers after renaming
// Keep this a power of two so the index type covers it exactly
`define FP_NUM_PHYS_REGS 64

// Width of one FP register in bits
// Double precision values, single values are NaN-boxed upstream
`define FP_DATA_W 64

`endif

// File: src/fprf_pkg.sv
// Shared types for the FP register-read path: register index, data bus, FP opcode enum
`include "fprf_macros.svh"

package fprf_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data path types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Physical register index, wide enough for every register
    typedef logic [$clog2(`FP_NUM_PHYS_REGS)-1:0] phreg_t;

    // One register value
    typedef logic [`FP_DATA_W-1:0] bus64_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FP opcodes carried with an issued instruction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        FP_ADD  = 3'd0,     // Reset value of the captured op
        FP_SUB  = 3'd1,
        FP_MUL  = 3'd2,
        FP_DIV  = 3'd3,
        FP_MADD = 3'd4,     // Fused a*b+c, uses all three sources
        FP_MSUB = 3'd5,     // Fused a*b-c
        FP_SQRT = 3'd6      // Single source
    } fp_op_t;

endpackage

// File: src/fp_read_if.sv
// Read bundle between operand stage and FP register file: three addresses, three data words
`timescale 1ns/1ps

interface fp_read_if import fprf_pkg::*; ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read address side, driven by the operand stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    phreg_t addr1;      // Source 1
    phreg_t addr2;      // Source 2
    phreg_t addr3;      // Source 3, only used by fused ops

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read data side, returned combinationally by the register file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    bus64_t data1;
    bus64_t data2;
    bus64_t data3;

    // Operand stage side
    modport requester (
        output addr1,
        output addr2,
        output addr3,
        input  data1,
        input  data2,
        input  data3
    );

    // Register file side
    modport responder (
        input  addr1,
        input  addr2,
        input  addr3,
        output data1,
        output data2,
        output data3
    );

endinterface

// File: src/fp_regfile.sv
// Physical FP register file: two write ports, three read ports, same-cycle writeback bypass
`timescale 1ns/1ps
`include "fprf_macros.svh"

module fp_regfile import fprf_pkg::*; (
    input  logic                      clk_i,
    // Writeback ports, one entry per port
    input  logic   [`FP_NUM_WB-1:0]   wb_valid_i,
    input  phreg_t [`FP_NUM_WB-1:0]   wb_addr_i,
    input  bus64_t [`FP_NUM_WB-1:0]   wb_data_i,
    // Read ports
    fp_read_if.responder              rd
);

    localparam int NUM_RD = 3;              // Read ports on the interface

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    bus64_t regs [`FP_NUM_PHYS_REGS];       // Register 0 is a normal register here

    // Read ports flattened to arrays so one loop serves all three
    phreg_t                 rd_addr  [NUM_RD];
    bus64_t                 rd_data  [NUM_RD];
    logic [`FP_NUM_WB-1:0]  byp_hit  [NUM_RD];  // Per read port, which WB port matches
    bus64_t                 byp_data [NUM_RD];  // Merged data of the matching WB ports

    assign rd_addr[0] = rd.addr1;
    assign rd_addr[1] = rd.addr2;
    assign rd_addr[2] = rd.addr3;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read with bypass
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // A writeback in flight this cycle wins over the stored value.
    // Renaming keeps valid WB addresses distinct, so at most one hit
    // per read port and an OR merge is enough.
    always_comb begin
        for (int p = 0; p < NUM_RD; p++) begin
            byp_hit[p]  = '0;
            byp_data[p] = '0;
            for (int w = 0; w < `FP_NUM_WB; w++) begin
                if (wb_valid_i[w] && (wb_addr_i[w] == rd_addr[p])) begin
                    byp_hit[p][w] = 1'b1;
                    byp_data[p]   = byp_data[p] | wb_data_i[w];
                end
            end
            // Each port selects on its own hit vector
            if (|byp_hit[p]) begin
                rd_data[p] = byp_data[p];
            end else begin
                rd_data[p] = regs[rd_addr[p]];
            end
        end
    end

    assign rd.data1 = rd_data[0];
    assign rd.data2 = rd_data[1];
    assign rd.data3 = rd_data[2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Every valid port updates its register at the edge
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < `FP_NUM_WB; w++) begin
            if (wb_valid_i[w]) begin
                regs[wb_addr_i[w]] <= wb_data_i[w];
            end
        end
    end

endmodule

// File: src/fp_operand_stage.sv
// Register-read stage: drives read addresses, captures operands, opcode and destination under stall
`timescale 1ns/1ps

module fp_operand_stage import fprf_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // Pipeline control
    input  logic                stall_i,        // Holds the output register
    // Issue side
    input  logic                issue_valid_i,
    input  fp_op_t              issue_op_i,
    input  phreg_t              issue_dest_i,
    input  phreg_t              issue_src1_i,
    input  phreg_t              issue_src2_i,
    input  phreg_t              issue_src3_i,
    // Register file read ports
    fp_read_if.requester        rd,
    // Captured instruction towards execution
    output logic                out_valid_o,
    output fp_op_t              out_op_o,
    output phreg_t              out_dest_o,
    output bus64_t              out_opnd1_o,
    output bus64_t              out_opnd2_o,
    output bus64_t              out_opnd3_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sources go straight to the register file every cycle.
    // Upstream keeps the issue steady during a stall, so the
    // returned data also tracks writebacks to those sources.
    assign rd.addr1 = issue_src1_i;
    assign rd.addr2 = issue_src2_i;
    assign rd.addr3 = issue_src3_i;

    // Output register contents
    logic   valid_q;
    fp_op_t op_q;
    phreg_t dest_q;
    bus64_t opnd1_q;
    bus64_t opnd2_q;
    bus64_t opnd3_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            op_q    <= FP_ADD;                  // Encoding zero
            dest_q  <= '0;
            opnd1_q <= '0;
            opnd2_q <= '0;
            opnd3_q <= '0;
        end else if (!stall_i) begin
            // Unstalled edge, take whatever is presented
            valid_q <= issue_valid_i;           // Drops when no issue this cycle
            op_q    <= issue_op_i;
            dest_q  <= issue_dest_i;
            opnd1_q <= rd.data1;                // Already bypassed in the register file
            opnd2_q <= rd.data2;
            opnd3_q <= rd.data3;
        end
        // Stalled edge, everything holds
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign out_valid_o = valid_q;
    assign out_op_o    = op_q;
    assign out_dest_o  = dest_q;
    assign out_opnd1_o = opnd1_q;   // Source 1 value
    assign out_opnd2_o = opnd2_q;   // Source 2 value
    assign out_opnd3_o = opnd3_q;   // Source 3 value

endmodule

// File: src/fp_regread_top.sv
// Top level of the FP register-read path: register file and operand stage joined by fp_read_if
`timescale 1ns/1ps
`include "fprf_macros.svh"

module fp_regread_top import fprf_pkg::*; (
    // Control
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    stall_i,
    // Writeback bus, one entry per port
    input  logic   [`FP_NUM_WB-1:0] wb_valid_i,
    input  phreg_t [`FP_NUM_WB-1:0] wb_addr_i,
    input  bus64_t [`FP_NUM_WB-1:0] wb_data_i,
    // Issued instruction
    input  logic                    issue_valid_i,
    input  fp_op_t                  issue_op_i,
    input  phreg_t                  issue_dest_i,
    input  phreg_t                  issue_src1_i,
    input  phreg_t                  issue_src2_i,
    input  phreg_t                  issue_src3_i,
    // Captured instruction with operands
    output logic                    out_valid_o,
    output fp_op_t                  out_op_o,
    output phreg_t                  out_dest_o,
    output bus64_t                  out_opnd1_o,
    output bus64_t                  out_opnd2_o,
    output bus64_t                  out_opnd3_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read bundle, purely combinational path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fp_read_if rd_if ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // No reset, contents come only from writebacks
    fp_regfile regfile_inst (
        .clk_i      (clk_i),
        .wb_valid_i (wb_valid_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i),
        .rd         (rd_if.responder)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operand stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One cycle from taken issue to outputs
    fp_operand_stage operand_stage_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .issue_dest_i  (issue_dest_i),
        .issue_src1_i  (issue_src1_i),
        .issue_src2_i  (issue_src2_i),
        .issue_src3_i  (issue_src3_i),
        .rd            (rd_if.requester),
        .out_valid_o   (out_valid_o),
        .out_op_o      (out_op_o),
        .out_dest_o    (out_dest_o),
        .out_opnd1_o   (out_opnd1_o),
        .out_opnd2_o   (out_opnd2_o),
        .out_opnd3_o   (out_opnd3_o)
    );

endmodule

// File: testbench/fp_regread_asserts.sv
// Bound concurrent checks on the FP register-read top: writeback uniqueness, reset, stall hold
`timescale 1ns/1ps
`include "fprf_macros.svh"

module fp_regread_asserts import fprf_pkg::*; (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    stall_i,
    input logic   [`FP_NUM_WB-1:0] wb_valid_i,
    input phreg_t [`FP_NUM_WB-1:0] wb_addr_i,
    input logic                    out_valid_o,
    input fp_op_t                  out_op_o,
    input phreg_t                  out_dest_o,
    input bus64_t                  out_opnd1_o,
    input bus64_t                  out_opnd2_o,
    input bus64_t                  out_opnd3_o
);

    int fail_cnt = 0;                       // Failed assertions so far

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Renaming keeps the two writeback targets apart
    property wb_addr_unique;
        @(posedge clk_i) (wb_valid_i[0] && wb_valid_i[1]) |-> (wb_addr_i[0] != wb_addr_i[1]);
    endproperty

    property valid_low_in_reset;
        @(posedge clk_i) !rst_n_i |-> !out_valid_o;
    endproperty

    // Stalled edge leaves the whole output register untouched
    property stall_holds_outputs;
        @(posedge clk_i) disable iff (!rst_n_i)
            stall_i |=> $stable({out_valid_o, out_op_o, out_dest_o,
                                 out_opnd1_o, out_opnd2_o, out_opnd3_o});
    endproperty

    a_wb_addr_unique:  assert property (wb_addr_unique)
        else begin
            $error("Both writeback ports target the same register");
            fail_cnt++;
        end
    a_reset_valid:     assert property (valid_low_in_reset)
        else begin
            $error("out_valid_o high while reset is active");
            fail_cnt++;
        end
    a_stall_hold:      assert property (stall_holds_outputs)
        else begin
            $error("Outputs changed across a stalled edge");
            fail_cnt++;
        end

endmodule

// Attach to every instance of the top level
bind fp_regread_top fp_regread_asserts asserts_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .stall_i     (stall_i),
    .wb_valid_i  (wb_valid_i),
    .wb_addr_i   (wb_addr_i),
    .out_valid_o (out_valid_o),
    .out_op_o    (out_op_o),
    .out_dest_o  (out_dest_o),
    .out_opnd1_o (out_opnd1_o),
    .out_opnd2_o (out_opnd2_o),
    .out_opnd3_o (out_opnd3_o)
);

// File: testbench/fp_regread_tb.sv
// Testbench for the FP register-read top: stimulus table, shadow register model, compare tasks
`timescale 1ns/1ps
`include "fprf_macros.svh"

module fp_regread_tb import fprf_pkg::*; ();

    localparam int RESET_TIMEOUT = 20;      // Cycles allowed for reset release

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    stall_i;
    logic   [`FP_NUM_WB-1:0] wb_valid_i;
    phreg_t [`FP_NUM_WB-1:0] wb_addr_i;
    bus64_t [`FP_NUM_WB-1:0] wb_data_i;
    logic                    issue_valid_i;
    fp_op_t                  issue_op_i;
    phreg_t                  issue_dest_i;
    phreg_t                  issue_src1_i;
    phreg_t                  issue_src2_i;
    phreg_t                  issue_src3_i;
    logic                    out_valid_o;
    fp_op_t                  out_op_o;
    phreg_t                  out_dest_o;
    bus64_t                  out_opnd1_o;
    bus64_t                  out_opnd2_o;
    bus64_t                  out_opnd3_o;

    // One cycle of stimulus plus the outputs expected after its rising edge
    typedef struct {
        string                   name;
        logic   [`FP_NUM_WB-1:0] wb_valid;
        phreg_t [`FP_NUM_WB-1:0] wb_addr;
        bus64_t [`FP_NUM_WB-1:0] wb_data;
        logic                    issue_valid;
        fp_op_t                  op;
        phreg_t                  dest;
        phreg_t [2:0]            src;
        logic                    stall;
        logic                    exp_valid;
        fp_op_t                  exp_op;
        phreg_t                  exp_dest;
        bus64_t [2:0]            exp_opnd;
    } row_t;

    row_t         rows[$];
    bus64_t       shadow [`FP_NUM_PHYS_REGS];  // Reference copy of the register file
    integer       seed = 70663;
    logic         mdl_valid;                   // Reference output register
    fp_op_t       mdl_op;
    phreg_t       mdl_dest;
    bus64_t [2:0] mdl_opnd;

    fp_regread_top fp_regread_top_inst (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Failure reporting and compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_valid(string name, logic exp, logic act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s valid: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_op(string name, fp_op_t exp, fp_op_t act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s op: expected %s, actual %s (%0d)",
                                name, exp.name(), act.name(), act));
    endtask

    task automatic check_dest(string name, phreg_t exp, phreg_t act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s dest: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_operand(string name, bus64_t exp, bus64_t act);
        if (act !== exp)
            abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    endtask

    // Bound properties on the top level
    task automatic check_assertions(string name);
        if (fp_regread_top_inst.asserts_inst.fail_cnt != 0)
            abort_run($sformatf("A DUT assertion failed by test %s", name));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and table construction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic bus64_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    // Stored value unless a writeback of the same cycle targets it
    function automatic bus64_t model_read(phreg_t addr, row_t r);
        bus64_t val;
        val = shadow[addr];
        for (int w = 0; w < `FP_NUM_WB; w++) begin
            if (r.wb_valid[w] && (r.wb_addr[w] == addr)) val = r.wb_data[w];
        end
        return val;
    endfunction

    task automatic add_row(string name, logic [1:0] wbv, phreg_t wa0, phreg_t wa1,
                           logic iv, fp_op_t op, phreg_t dest,
                           phreg_t s1, phreg_t s2, phreg_t s3, logic stall);
        row_t r;
        r.name = name;
        r.wb_valid = wbv;
        r.wb_addr[0] = wa0;
        r.wb_addr[1] = wa1;
        r.wb_data[0] = rand64();
        r.wb_data[1] = rand64();
        r.issue_valid = iv;
        r.op = op;
        r.dest = dest;
        r.src[0] = s1;
        r.src[1] = s2;
        r.src[2] = s3;
        r.stall = stall;
        if (!stall) begin                       // Unstalled edge loads the output register
            mdl_valid = iv;
            mdl_op = op;
            mdl_dest = dest;
            for (int p = 0; p < 3; p++) mdl_opnd[p] = model_read(r.src[p], r);
        end
        r.exp_valid = mdl_valid;
        r.exp_op = mdl_op;
        r.exp_dest = mdl_dest;
        r.exp_opnd = mdl_opnd;
        for (int w = 0; w < `FP_NUM_WB; w++) begin  // Writes land at the same edge
            if (wbv[w]) shadow[r.wb_addr[w]] = r.wb_data[w];
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        for (int i = 0; i < `FP_NUM_PHYS_REGS / 2; i++) begin  // Fill every register
            add_row("preload", 2'b11, phreg_t'(2 * i), phreg_t'(2 * i + 1),
                    1'b0, FP_ADD, 6'd0, 6'd0, 6'd0, 6'd0, 1'b0);
        end
        add_row("rd_both_ports",   2'b00, 6'd0,  6'd0,  1'b1, FP_MADD, 6'd40, 6'd4,  6'd5,  6'd6,  1'b0);
        add_row("byp_p0_s1_p1_s3", 2'b11, 6'd7,  6'd9,  1'b1, FP_ADD,  6'd41, 6'd7,  6'd8,  6'd9,  1'b0);
        add_row("byp_p1_s2",       2'b11, 6'd12, 6'd13, 1'b1, FP_SUB,  6'd42, 6'd14, 6'd13, 6'd12, 1'b0);
        add_row("s3_own_match",    2'b11, 6'd17, 6'd15, 1'b1, FP_MUL,  6'd43, 6'd17, 6'd15, 6'd16, 1'b0);
        add_row("stall_take",      2'b00, 6'd0,  6'd0,  1'b1, FP_MUL,  6'd44, 6'd21, 6'd22, 6'd23, 1'b0);
        add_row("stall_hold0",     2'b11, 6'd25, 6'd26, 1'b1, FP_DIV,  6'd45, 6'd25, 6'd26, 6'd27, 1'b1);
        add_row("stall_hold1",     2'b11, 6'd27, 6'd25, 1'b1, FP_DIV,  6'd45, 6'd25, 6'd26, 6'd27, 1'b1);
        add_row("stall_release",   2'b00, 6'd0,  6'd0,  1'b1, FP_DIV,  6'd45, 6'd25, 6'd26, 6'd27, 1'b0);
        add_row("idle_drop",       2'b01, 6'd30, 6'd0,  1'b0, FP_ADD,  6'd0,  6'd0,  6'd0,  6'd0,  1'b0);
        add_row("b2b_msub",        2'b10, 6'd0,  6'd31, 1'b1, FP_MSUB, 6'd46, 6'd30, 6'd31, 6'd32, 1'b0);
        add_row("b2b_sqrt",        2'b00, 6'd0,  6'd0,  1'b1, FP_SQRT, 6'd47, 6'd31, 6'd0,  6'd0,  1'b0);
        add_row("b2b_add",         2'b11, 6'd33, 6'd34, 1'b1, FP_ADD,  6'd48, 6'd34, 6'd33, 6'd35, 1'b0);
        add_row("drain",           2'b00, 6'd0,  6'd0,  1'b0, FP_ADD,  6'd0,  6'd0,  6'd0,  6'd0,  1'b0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drive and check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_row(row_t r);
        wb_valid_i    = r.wb_valid;
        wb_addr_i     = r.wb_addr;
        wb_data_i     = r.wb_data;
        issue_valid_i = r.issue_valid;
        issue_op_i    = r.op;
        issue_dest_i  = r.dest;
        issue_src1_i  = r.src[0];
        issue_src2_i  = r.src[1];
        issue_src3_i  = r.src[2];
        stall_i       = r.stall;
    endtask

    task automatic check_row(row_t r);
        check_valid(r.name, r.exp_valid, out_valid_o);
        if (r.exp_valid) begin                  // Payload only matters with a valid issue
            check_op(r.name, r.exp_op, out_op_o);
            check_dest(r.name, r.exp_dest, out_dest_o);
            check_operand({r.name, " opnd1"}, r.exp_opnd[0], out_opnd1_o);
            check_operand({r.name, " opnd2"}, r.exp_opnd[1], out_opnd2_o);
            check_operand({r.name, " opnd3"}, r.exp_opnd[2], out_opnd3_o);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!rst_n_i && (cycles < RESET_TIMEOUT)) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!rst_n_i) abort_run("Reset was not released within the timeout");
    endtask

    initial begin
        rst_n_i       = 1'b0;
        stall_i       = 1'b0;
        wb_valid_i    = '0;
        wb_addr_i     = '0;
        wb_data_i     = '0;
        issue_valid_i = 1'b0;
        issue_op_i    = FP_ADD;
        issue_dest_i  = '0;
        issue_src1_i  = '0;
        issue_src2_i  = '0;
        issue_src3_i  = '0;
        mdl_valid     = 1'b0;                   // Model starts in the reset state
        mdl_op        = FP_ADD;
        mdl_dest      = '0;
        mdl_opnd      = '0;
        build_table();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        wait_reset_release();
        check_valid("after_reset", 1'b0, out_valid_o);
        check_op("after_reset", FP_ADD, out_op_o);
        check_dest("after_reset", '0, out_dest_o);
        check_operand("after_reset opnd1", '0, out_opnd1_o);
        check_operand("after_reset opnd2", '0, out_opnd2_o);
        check_operand("after_reset opnd3", '0, out_opnd3_o);
        check_assertions("after_reset");
        for (int i = 0; i < rows.size(); i++) begin
            drive_row(rows[i]);
            @(negedge clk_i);                   // One cycle latency, outputs settled here
            check_row(rows[i]);
            check_assertions(rows[i].name);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: all.f
+incdir+src
src/fprf_pkg.sv
src/fp_read_if.sv
src/fp_regfile.sv
src/fp_operand_stage.sv
src/fp_regread_top.sv
testbench/fp_regread_asserts.sv
testbench/fp_regread_tb.sv
